/* all.f */
+incdir+hdl
hdl/tlb_pkg.sv
hdl/tlb_table.sv
hdl/tlb_lookup_arb.sv
hdl/tlb_fsm.sv
hdl/tlb_credit_counter.sv
hdl/tlb_region_top.sv
testbench/tlb_region_sva.sv
testbench/tb_tlb_region.sv

/* hdl/tlb_credit_counter.sv */
`timescale 1ns/1ns

`include "tlb_defs.svh"

module tlb_credit_counter #(
    parameter int N_CREDITS = `TLB_N_CREDITS
) (
    input  logic aclk,
    input  logic aresetn,
    // One credit per DMA strobe
    input  logic take,
    // One credit back per transfer done
    input  logic give,
    output logic has_credit
);
    import tlb_pkg::*;

    localparam cred_t CRED_MAX = cred_t'(N_CREDITS);

    cred_t count_q;

    // Starts full, saturates at both ends
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            count_q <= CRED_MAX;
        end else if (take && !give) begin
            if (count_q != '0) begin
                count_q <= count_q - cred_t'(1);
            end
        end else if (give && !take) begin
            if (count_q != CRED_MAX) begin
                count_q <= count_q + cred_t'(1);
            end
        end
    end

    assign has_credit = (count_q != '0);

endmodule

/* hdl/tlb_defs.svh */
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// ----------------------------------------
// Address geometry
// ----------------------------------------

// Virtual and physical address widths
`define TLB_VADDR_BITS 32
`define TLB_PADDR_BITS 32

// Small page of 4 KiB
`define TLB_PG_BITS 12

// Index bits of the direct-mapped table, 16 entries
`define TLB_ORDER 4

// ----------------------------------------
// Request fields and credits
// ----------------------------------------
`define TLB_PID_BITS 6
`define TLB_LEN_BITS 16

// Outstanding transfers per direction
`define TLB_N_CREDITS 4

`endif

/* hdl/tlb_fsm.sv */
`timescale 1ns/1ns

`include "tlb_defs.svh"

module tlb_fsm #(
    parameter bit IS_WR = 1'b0
) (
    input  logic               aclk,
    input  logic               aresetn,
    // Virtual request, taken only when idle
    input  logic               req_valid,
    input  tlb_pkg::req_t      req,
    // Mutex on the shared lookup port
    input  logic               grant,
    output logic               lock,
    output logic               unlock,
    // Lookup port
    output logic               lookup_valid,
    output tlb_pkg::lookup_t   lookup,
    input  logic               rsp_valid,
    input  tlb_pkg::tlb_rsp_t  rsp,
    // Transfer credits
    input  logic               has_credit,
    // Translated request
    output logic               dma_valid,
    output tlb_pkg::dma_req_t  dma,
    // Page fault
    output logic               pf_valid,
    output tlb_pkg::pfault_t   pf,
    input  logic               restart,
    output logic               pf_pending
);
    import tlb_pkg::*;

    fsm_state_t state_q;
    fsm_state_t state_d;

    // Captured request and its translation
    req_t req_q;
    ppn_t ppn_q;

    // Answer to our own lookup
    logic rsp_hit;
    logic rsp_miss;

    assign rsp_hit  = (state_q == ST_WAIT_RSP) && rsp_valid && rsp.hit;
    assign rsp_miss = (state_q == ST_WAIT_RSP) && rsp_valid && !rsp.hit;

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_valid) begin
                    state_d = ST_LOCK;
                end
            end
            ST_LOCK: begin
                if (grant) begin
                    state_d = ST_LOOKUP;
                end
            end
            // Single lookup strobe
            ST_LOOKUP: begin
                state_d = ST_WAIT_RSP;
            end
            ST_WAIT_RSP: begin
                if (rsp_hit) begin
                    state_d = ST_WAIT_CRED;
                end else if (rsp_miss) begin
                    state_d = ST_FAULT;
                end
            end
            ST_WAIT_CRED: begin
                if (has_credit) begin
                    state_d = ST_ISSUE;
                end
            end
            ST_ISSUE: begin
                state_d = ST_IDLE;
            end
            // Host maps the page, then restarts the lookup
            ST_FAULT: begin
                if (restart) begin
                    state_d = ST_LOCK;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q  <= ST_IDLE;
            pf_valid <= 1'b0;
        end else begin
            state_q  <= state_d;
            // Strobe on entry to the fault state
            pf_valid <= rsp_miss;
        end
    end

    // Requests while busy are dropped
    always_ff @(posedge aclk) begin
        if ((state_q == ST_IDLE) && req_valid) begin
            req_q <= req;
        end
        if (rsp_hit) begin
            ppn_q <= rsp.ppn;
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------

    // Hold the lock request until granted
    assign lock   = (state_q == ST_LOCK) && !grant;
    // Release as soon as the answer is in
    assign unlock = (state_q == ST_WAIT_RSP) && rsp_valid;

    assign lookup_valid = (state_q == ST_LOOKUP);
    assign lookup.vpn   = req_q.vaddr[`TLB_VADDR_BITS-1:`TLB_PG_BITS];
    assign lookup.pid   = req_q.pid;

    // Physical address is ppn joined with the request offset
    assign dma_valid = (state_q == ST_ISSUE);
    assign dma.paddr = {ppn_q, req_q.vaddr[`TLB_PG_BITS-1:0]};
    assign dma.len   = req_q.len;
    assign dma.pid   = req_q.pid;

    assign pf.vaddr   = req_q.vaddr;
    assign pf.pid     = req_q.pid;
    assign pf.wr      = IS_WR;
    assign pf_pending = (state_q == ST_FAULT);

endmodule

/* hdl/tlb_lookup_arb.sv */
`timescale 1ns/1ns

module tlb_lookup_arb (
    input  logic              aclk,
    input  logic              aresetn,
    // Mutex requests
    input  logic              rd_lock,
    input  logic              rd_unlock,
    input  logic              wr_lock,
    input  logic              wr_unlock,
    output logic              rd_grant,
    output logic              wr_grant,
    // Lookups from both machines
    input  logic              rd_lookup_valid,
    input  logic              wr_lookup_valid,
    input  tlb_pkg::lookup_t  rd_lookup,
    input  tlb_pkg::lookup_t  wr_lookup,
    // Towards the table
    output logic              lookup_valid,
    output tlb_pkg::lookup_t  lookup
);

    // Mutex taken, and by which side
    logic busy_q;
    logic owner_wr_q;

    // ----------------------------------------
    // Mutex
    // ----------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy_q     <= 1'b0;
            owner_wr_q <= 1'b0;
        end else if (!busy_q) begin
            // Read wins a tie
            if (rd_lock) begin
                busy_q     <= 1'b1;
                owner_wr_q <= 1'b0;
            end else if (wr_lock) begin
                busy_q     <= 1'b1;
                owner_wr_q <= 1'b1;
            end
        end else if (owner_wr_q ? wr_unlock : rd_unlock) begin
            // Only the owner may release
            busy_q <= 1'b0;
        end
    end

    assign rd_grant = busy_q && !owner_wr_q;
    assign wr_grant = busy_q && owner_wr_q;

    // Steer the owner's lookup to the table
    assign lookup_valid = busy_q && (owner_wr_q ? wr_lookup_valid : rd_lookup_valid);
    assign lookup       = owner_wr_q ? wr_lookup : rd_lookup;

endmodule

/* hdl/tlb_pkg.sv */
`include "tlb_defs.svh"

package tlb_pkg;

    // ----------------------------------------
    // Width types
    // ----------------------------------------
    typedef logic [`TLB_VADDR_BITS-1:0] vaddr_t;
    typedef logic [`TLB_PADDR_BITS-1:0] paddr_t;

    // Page numbers, address minus page offset
    typedef logic [`TLB_VADDR_BITS-`TLB_PG_BITS-1:0] vpn_t;
    typedef logic [`TLB_PADDR_BITS-`TLB_PG_BITS-1:0] ppn_t;
    typedef logic [`TLB_PG_BITS-1:0] pg_off_t;

    // Low vpn bits index the table, the rest is the tag
    typedef logic [`TLB_ORDER-1:0] tlb_idx_t;
    typedef logic [`TLB_VADDR_BITS-`TLB_PG_BITS-`TLB_ORDER-1:0] tlb_tag_t;

    typedef logic [`TLB_PID_BITS-1:0] pid_t;
    typedef logic [`TLB_LEN_BITS-1:0] len_t;

    // Holds 0 up to the full credit count
    typedef logic [$clog2(`TLB_N_CREDITS+1)-1:0] cred_t;

    // ----------------------------------------
    // Bundles
    // ----------------------------------------

    // Virtual request from the user region
    typedef struct packed {
        vaddr_t vaddr;
        len_t   len;
        pid_t   pid;
    } req_t;

    // Translated request towards the DMA engine
    typedef struct packed {
        paddr_t paddr;
        len_t   len;
        pid_t   pid;
    } dma_req_t;

    // Host table write
    typedef struct packed {
        vpn_t vpn;
        pid_t pid;
        ppn_t ppn;
    } map_t;

    typedef struct packed {
        vpn_t vpn;
        pid_t pid;
    } lookup_t;

    typedef struct packed {
        logic hit;
        ppn_t ppn;
    } tlb_rsp_t;

    // Page fault report, wr marks the write direction
    typedef struct packed {
        vaddr_t vaddr;
        pid_t   pid;
        logic   wr;
    } pfault_t;

    // Translation FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOCK,
        ST_LOOKUP,
        ST_WAIT_RSP,
        ST_WAIT_CRED,
        ST_ISSUE,
        ST_FAULT
    } fsm_state_t;

endpackage

/* hdl/tlb_region_top.sv */
`timescale 1ns/1ns

`include "tlb_defs.svh"

module tlb_region_top (
    input  logic               aclk,
    input  logic               aresetn,
    // Virtual requests
    input  logic               rd_req_valid,
    input  tlb_pkg::req_t      rd_req,
    input  logic               wr_req_valid,
    input  tlb_pkg::req_t      wr_req,
    // Table fill
    input  logic               map_valid,
    input  tlb_pkg::map_t      map,
    // Translated DMA requests
    output logic               rd_dma_valid,
    output tlb_pkg::dma_req_t  rd_dma,
    output logic               wr_dma_valid,
    output tlb_pkg::dma_req_t  wr_dma,
    // Transfer done
    input  logic               rxfer,
    input  logic               wxfer,
    // Page faults
    output logic               rd_pf_valid,
    output tlb_pkg::pfault_t   rd_pf,
    output logic               wr_pf_valid,
    output tlb_pkg::pfault_t   wr_pf,
    input  logic               rd_restart,
    input  logic               wr_restart,
    output logic               pf_irq
);
    import tlb_pkg::*;

    // ----------------------------------------
    // Internal wires
    // ----------------------------------------
    logic     rd_lock, rd_unlock, rd_grant;
    logic     wr_lock, wr_unlock, wr_grant;
    logic     rd_lookup_valid, wr_lookup_valid, lookup_valid;
    lookup_t  rd_lookup, wr_lookup, lookup;
    logic     rsp_valid;
    tlb_rsp_t rsp;
    logic     rd_has_credit, wr_has_credit;
    logic     rd_pf_pending, wr_pf_pending;

    tlb_table inst_table (
        .aclk(aclk), .aresetn(aresetn),
        .map_valid(map_valid), .map(map),
        .lookup_valid(lookup_valid), .lookup(lookup),
        .rsp_valid(rsp_valid), .rsp(rsp)
    );

    tlb_lookup_arb inst_arb (
        .aclk(aclk), .aresetn(aresetn),
        .rd_lock(rd_lock), .rd_unlock(rd_unlock),
        .wr_lock(wr_lock), .wr_unlock(wr_unlock),
        .rd_grant(rd_grant), .wr_grant(wr_grant),
        .rd_lookup_valid(rd_lookup_valid), .wr_lookup_valid(wr_lookup_valid),
        .rd_lookup(rd_lookup), .wr_lookup(wr_lookup),
        .lookup_valid(lookup_valid), .lookup(lookup)
    );

    // ----------------------------------------
    // Per-direction machines and credits
    // ----------------------------------------
    tlb_fsm #(.IS_WR(1'b0)) inst_fsm_rd (
        .aclk(aclk), .aresetn(aresetn),
        .req_valid(rd_req_valid), .req(rd_req),
        .grant(rd_grant), .lock(rd_lock), .unlock(rd_unlock),
        .lookup_valid(rd_lookup_valid), .lookup(rd_lookup),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .has_credit(rd_has_credit),
        .dma_valid(rd_dma_valid), .dma(rd_dma),
        .pf_valid(rd_pf_valid), .pf(rd_pf),
        .restart(rd_restart), .pf_pending(rd_pf_pending)
    );

    tlb_fsm #(.IS_WR(1'b1)) inst_fsm_wr (
        .aclk(aclk), .aresetn(aresetn),
        .req_valid(wr_req_valid), .req(wr_req),
        .grant(wr_grant), .lock(wr_lock), .unlock(wr_unlock),
        .lookup_valid(wr_lookup_valid), .lookup(wr_lookup),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .has_credit(wr_has_credit),
        .dma_valid(wr_dma_valid), .dma(wr_dma),
        .pf_valid(wr_pf_valid), .pf(wr_pf),
        .restart(wr_restart), .pf_pending(wr_pf_pending)
    );

    tlb_credit_counter #(.N_CREDITS(`TLB_N_CREDITS)) inst_cred_rd (
        .aclk(aclk), .aresetn(aresetn),
        .take(rd_dma_valid), .give(rxfer), .has_credit(rd_has_credit)
    );

    tlb_credit_counter #(.N_CREDITS(`TLB_N_CREDITS)) inst_cred_wr (
        .aclk(aclk), .aresetn(aresetn),
        .take(wr_dma_valid), .give(wxfer), .has_credit(wr_has_credit)
    );

    // Level while either direction waits for restart
    assign pf_irq = rd_pf_pending | wr_pf_pending;

endmodule

/* hdl/tlb_table.sv */
`timescale 1ns/1ns

`include "tlb_defs.svh"

module tlb_table (
    input  logic               aclk,
    input  logic               aresetn,
    // Map write from the host
    input  logic               map_valid,
    input  tlb_pkg::map_t      map,
    // Lookup port, answer one cycle later
    input  logic               lookup_valid,
    input  tlb_pkg::lookup_t   lookup,
    output logic               rsp_valid,
    output tlb_pkg::tlb_rsp_t  rsp
);
    import tlb_pkg::*;

    localparam int N_ENTRIES = 1 << `TLB_ORDER;
    localparam int VPN_BITS = `TLB_VADDR_BITS - `TLB_PG_BITS;

    // ----------------------------------------
    // Entry storage
    // ----------------------------------------
    logic [N_ENTRIES-1:0] valid_q;
    tlb_tag_t             tag_q [N_ENTRIES];
    pid_t                 pid_q [N_ENTRIES];
    ppn_t                 ppn_q [N_ENTRIES];

    // Split of the map vpn
    tlb_idx_t map_idx;
    tlb_tag_t map_tag;

    // Registered lookup
    logic     lk_valid_q;
    tlb_idx_t lk_idx_q;
    tlb_tag_t lk_tag_q;
    pid_t     lk_pid_q;

    assign map_idx = map.vpn[`TLB_ORDER-1:0];
    assign map_tag = map.vpn[VPN_BITS-1:`TLB_ORDER];

    // Only the valid bits are cleared, a write always revalidates its entry
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            valid_q <= '0;
        end else if (map_valid) begin
            valid_q[map_idx] <= 1'b1;
        end
    end

    // Overwrite whatever sat at this index
    always_ff @(posedge aclk) begin
        if (map_valid) begin
            tag_q[map_idx] <= map_tag;
            pid_q[map_idx] <= map.pid;
            ppn_q[map_idx] <= map.ppn;
        end
    end

    // ----------------------------------------
    // Lookup
    // ----------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            lk_valid_q <= 1'b0;
        end else begin
            lk_valid_q <= lookup_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (lookup_valid) begin
            lk_idx_q <= lookup.vpn[`TLB_ORDER-1:0];
            lk_tag_q <= lookup.vpn[VPN_BITS-1:`TLB_ORDER];
            lk_pid_q <= lookup.pid;
        end
    end

    // Hit needs valid entry, same tag, same pid
    assign rsp_valid = lk_valid_q;
    assign rsp.hit   = valid_q[lk_idx_q] && (tag_q[lk_idx_q] == lk_tag_q) &&
                       (pid_q[lk_idx_q] == lk_pid_q);
    assign rsp.ppn   = ppn_q[lk_idx_q];

endmodule

/* testbench/tb_tlb_region.sv */
`timescale 1ns/1ns

`include "tlb_defs.svh"

module tb_tlb_region;
    import tlb_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 5;
    localparam int N_ENTRIES   = 1 << `TLB_ORDER;
    localparam int N_HIT       = 32;
    localparam int N_MISS      = 6;
    localparam int N_PAIR      = 8;
    // Every request the run issues
    localparam int N_REQS = 2 + N_HIT + N_MISS + 2 * N_PAIR + `TLB_N_CREDITS + 1;
    localparam int WATCHDOG_CYCLES = 200 * N_REQS + 100;

    // DUT ports
    logic     aclk;
    logic     aresetn;
    logic     rd_req_valid;
    req_t     rd_req;
    logic     wr_req_valid;
    req_t     wr_req;
    logic     map_valid;
    map_t     map;
    logic     rd_dma_valid;
    dma_req_t rd_dma;
    logic     wr_dma_valid;
    dma_req_t wr_dma;
    logic     rxfer;
    logic     wxfer;
    logic     rd_pf_valid;
    pfault_t  rd_pf;
    logic     wr_pf_valid;
    pfault_t  wr_pf;
    logic     rd_restart;
    logic     wr_restart;
    logic     pf_irq;

    // Table mirror, free credits and strobe counts per direction
    tlb_tag_t    m_tag [N_ENTRIES];
    pid_t        m_pid [N_ENTRIES];
    ppn_t        m_ppn [N_ENTRIES];
    int          m_cred [2];
    int          dma_exp [2];
    int          dma_seen [2];
    int          fault_exp [2];
    int          fault_seen [2];
    logic [31:0] rng_state;

    tlb_region_top dut0 (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // ----------------------------------------
    // Failure reporting and checks
    // ----------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_dma(input string name, input dma_req_t got, input dma_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_pf(input string name, input pfault_t got, input pfault_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // Interrupt level and single strobes
    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // ----------------------------------------
    // Random numbers and expected values
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Request that hits the mirrored entry at idx
    function automatic req_t make_req(input tlb_idx_t idx);
        req_t        r;
        logic [31:0] rnd;
        rnd     = next_random();
        r.vaddr = {m_tag[idx], idx, pg_off_t'(rnd)};
        r.len   = len_t'(rnd >> 16);
        r.pid   = m_pid[idx];
        return r;
    endfunction

    // Page number joined with the untouched offset
    function automatic dma_req_t expected_dma(input req_t r, input ppn_t ppn);
        dma_req_t d;
        d.paddr = {ppn, r.vaddr[`TLB_PG_BITS-1:0]};
        d.len   = r.len;
        d.pid   = r.pid;
        return d;
    endfunction

    // ----------------------------------------
    // Drivers
    // ----------------------------------------
    task automatic map_page(input vpn_t vpn, input pid_t pid, input ppn_t ppn);
        tlb_idx_t idx;
        idx = vpn[`TLB_ORDER-1:0];
        @(posedge aclk);
        #DRIVE_DELAY;
        map_valid = 1'b1;
        map.vpn   = vpn;
        map.pid   = pid;
        map.ppn   = ppn;
        @(posedge aclk);
        #DRIVE_DELAY;
        map_valid = 1'b0;
        m_tag[idx] = vpn[`TLB_VADDR_BITS-`TLB_PG_BITS-1:`TLB_ORDER];
        m_pid[idx] = pid;
        m_ppn[idx] = ppn;
    endtask

    task automatic drive_req(input bit is_wr, input req_t r);
        @(posedge aclk);
        #DRIVE_DELAY;
        if (is_wr) begin
            wr_req_valid = 1'b1;
            wr_req       = r;
        end else begin
            rd_req_valid = 1'b1;
            rd_req       = r;
        end
        @(posedge aclk);
        #DRIVE_DELAY;
        rd_req_valid = 1'b0;
        wr_req_valid = 1'b0;
    endtask

    // Both directions in the same cycle
    task automatic drive_both(input req_t rr, input req_t wr);
        @(posedge aclk);
        #DRIVE_DELAY;
        rd_req_valid = 1'b1;
        rd_req       = rr;
        wr_req_valid = 1'b1;
        wr_req       = wr;
        @(posedge aclk);
        #DRIVE_DELAY;
        rd_req_valid = 1'b0;
        wr_req_valid = 1'b0;
    endtask

    // Transfer done, one credit back
    task automatic return_credit(input bit is_wr);
        @(posedge aclk);
        #DRIVE_DELAY;
        if (is_wr) begin
            wxfer = 1'b1;
        end else begin
            rxfer = 1'b1;
        end
        @(posedge aclk);
        #DRIVE_DELAY;
        rxfer = 1'b0;
        wxfer = 1'b0;
        m_cred[is_wr]++;
    endtask

    task automatic pulse_restart(input bit is_wr);
        @(posedge aclk);
        #DRIVE_DELAY;
        if (is_wr) begin
            wr_restart = 1'b1;
        end else begin
            rd_restart = 1'b1;
        end
        @(posedge aclk);
        #DRIVE_DELAY;
        rd_restart = 1'b0;
        wr_restart = 1'b0;
    endtask

    // ----------------------------------------
    // Response handling
    // ----------------------------------------

    // Sampled at the falling edge, mid cycle
    task automatic wait_result(input bit is_wr, output logic got_pf,
                               output dma_req_t dma, output pfault_t pf);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge aclk);
            done = is_wr ? (wr_dma_valid || wr_pf_valid) : (rd_dma_valid || rd_pf_valid);
        end
        got_pf = is_wr ? wr_pf_valid : rd_pf_valid;
        dma    = is_wr ? wr_dma : rd_dma;
        pf     = is_wr ? wr_pf : rd_pf;
    endtask

    task automatic expect_dma(input bit is_wr, input req_t r, input ppn_t ppn);
        logic     got_pf;
        dma_req_t dma;
        pfault_t  pf;
        wait_result(is_wr, got_pf, dma, pf);
        if (got_pf) begin
            fail_run($sformatf("request to vaddr %h faulted where a translation was expected",
                               r.vaddr));
        end
        check_dma(is_wr ? "wr_dma" : "rd_dma", dma, expected_dma(r, ppn));
        m_cred[is_wr]--;
        dma_exp[is_wr]++;
    endtask

    // Fault, map the page, restart, then the translation
    task automatic run_fault(input bit is_wr, input req_t r, input ppn_t new_ppn);
        logic     got_pf;
        dma_req_t dma;
        pfault_t  pf;
        pfault_t  pf_exp;
        drive_req(is_wr, r);
        wait_result(is_wr, got_pf, dma, pf);
        if (!got_pf) begin
            fail_run($sformatf("request to vaddr %h was translated where a fault was expected",
                               r.vaddr));
        end
        fault_exp[is_wr]++;
        pf_exp.vaddr = r.vaddr;
        pf_exp.pid   = r.pid;
        pf_exp.wr    = is_wr;
        check_pf(is_wr ? "wr_pf" : "rd_pf", pf, pf_exp);
        check_flag("pf_irq", pf_irq, 1'b1);
        map_page(r.vaddr[`TLB_VADDR_BITS-1:`TLB_PG_BITS], r.pid, new_ppn);
        @(negedge aclk);
        check_flag("pf_irq", pf_irq, 1'b1);
        pulse_restart(is_wr);
        @(negedge aclk);
        check_flag("pf_irq", pf_irq, 1'b0);
        expect_dma(is_wr, r, new_ppn);
    endtask

    // Every DMA and fault strobe, to catch duplicates
    always @(negedge aclk) begin
        if (rd_dma_valid === 1'b1) begin
            dma_seen[0]++;
        end
        if (wr_dma_valid === 1'b1) begin
            dma_seen[1]++;
        end
        if (rd_pf_valid === 1'b1) begin
            fault_seen[0]++;
        end
        if (wr_pf_valid === 1'b1) begin
            fault_seen[1]++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired before all requests completed");
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        bit     dir;
        req_t   r;
        req_t   r2;
        tlb_idx_t idx;
        tlb_idx_t idx2;
        aresetn      = 1'b0;
        rd_req_valid = 1'b0;
        rd_req       = '0;
        wr_req_valid = 1'b0;
        wr_req       = '0;
        map_valid    = 1'b0;
        map          = '0;
        rxfer        = 1'b0;
        wxfer        = 1'b0;
        rd_restart   = 1'b0;
        wr_restart   = 1'b0;
        rng_state    = 32'h40c018c1;
        for (int d = 0; d < 2; d++) begin
            m_cred[d]     = `TLB_N_CREDITS;
            dma_exp[d]    = 0;
            dma_seen[d]   = 0;
            fault_exp[d]  = 0;
            fault_seen[d] = 0;
        end
        repeat (5) @(posedge aclk);
        #DRIVE_DELAY;
        aresetn = 1'b1;

        // Quiet outputs after reset
        @(negedge aclk);
        check_flag("rd_dma_valid", rd_dma_valid, 1'b0);
        check_flag("wr_dma_valid", wr_dma_valid, 1'b0);
        check_flag("rd_pf_valid", rd_pf_valid, 1'b0);
        check_flag("wr_pf_valid", wr_pf_valid, 1'b0);
        check_flag("pf_irq", pf_irq, 1'b0);

        // Empty table, any page faults
        for (int d = 0; d < 2; d++) begin
            r.vaddr = next_random();
            r.len   = len_t'(next_random());
            r.pid   = pid_t'(next_random());
            run_fault(d[0], r, ppn_t'(next_random()));
            return_credit(d[0]);
        end

        // Fill every entry
        for (int i = 0; i < N_ENTRIES; i++) begin
            map_page({tlb_tag_t'(next_random()), tlb_idx_t'(i)}, pid_t'(next_random()),
                     ppn_t'(next_random()));
        end

        // Random hits on either side
        for (int i = 0; i < N_HIT; i++) begin
            dir = 1'(next_random());
            idx = tlb_idx_t'(next_random());
            r   = make_req(idx);
            drive_req(dir, r);
            expect_dma(dir, r, m_ppn[idx]);
            return_credit(dir);
        end

        // Pid or tag mismatch
        for (int i = 0; i < N_MISS; i++) begin
            dir = i[0];
            idx = tlb_idx_t'(next_random());
            r   = make_req(idx);
            if (i[1]) begin
                r.pid = r.pid ^ pid_t'(1);
            end else begin
                r.vaddr[`TLB_VADDR_BITS-1] = ~r.vaddr[`TLB_VADDR_BITS-1];
            end
            run_fault(dir, r, ppn_t'(next_random()));
            return_credit(dir);
        end

        // Contention on the lookup port
        for (int i = 0; i < N_PAIR; i++) begin
            idx  = tlb_idx_t'(next_random());
            idx2 = tlb_idx_t'(next_random());
            r    = make_req(idx);
            r2   = make_req(idx2);
            drive_both(r, r2);
            fork
                expect_dma(1'b0, r, m_ppn[idx]);
                expect_dma(1'b1, r2, m_ppn[idx2]);
            join
            return_credit(1'b0);
            return_credit(1'b1);
        end

        // Drain all credits of one side, as the model counts them
        dir = 1'(next_random());
        while (m_cred[dir] > 0) begin
            idx = tlb_idx_t'(next_random());
            r   = make_req(idx);
            drive_req(dir, r);
            expect_dma(dir, r, m_ppn[idx]);
        end
        idx = tlb_idx_t'(next_random());
        r   = make_req(idx);
        drive_req(dir, r);
        // Held back while no credit is free
        repeat (30) begin
            @(negedge aclk);
            check_flag(dir ? "wr_dma_valid" : "rd_dma_valid",
                       dir ? wr_dma_valid : rd_dma_valid, 1'b0);
        end
        return_credit(dir);
        expect_dma(dir, r, m_ppn[idx]);
        while (m_cred[dir] < `TLB_N_CREDITS) begin
            return_credit(dir);
        end

        repeat (4) @(posedge aclk);
        if (dma_seen[0] != dma_exp[0] || dma_seen[1] != dma_exp[1]) begin
            fail_run($sformatf("DMA strobe count mismatch, rd %0d of %0d, wr %0d of %0d",
                               dma_seen[0], dma_exp[0], dma_seen[1], dma_exp[1]));
        end else if (fault_seen[0] != fault_exp[0] || fault_seen[1] != fault_exp[1]) begin
            fail_run($sformatf("fault strobe count mismatch, rd %0d of %0d, wr %0d of %0d",
                               fault_seen[0], fault_exp[0], fault_seen[1], fault_exp[1]));
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* testbench/tlb_region_sva.sv */
`timescale 1ns/1ns

module tlb_region_sva (
    input logic aclk,
    input logic aresetn,
    // Mutex grants
    input logic rd_grant,
    input logic wr_grant,
    // DMA strobes and their credit levels
    input logic rd_dma_valid,
    input logic wr_dma_valid,
    input logic rd_has_credit,
    input logic wr_has_credit,
    // Fault strobes and interrupt
    input logic rd_pf_valid,
    input logic wr_pf_valid,
    input logic pf_irq
);

    // ----------------------------------------
    // Mutex
    // ----------------------------------------

    // One owner at a time
    grant_exclusive: assert property (@(posedge aclk) disable iff (!aresetn)
        !(rd_grant && wr_grant))
        else $error("rd_grant and wr_grant high in the same cycle");

    // ----------------------------------------
    // Credits
    // ----------------------------------------
    rd_dma_needs_credit: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_dma_valid |-> rd_has_credit)
        else $error("read DMA strobe without a free credit");

    wr_dma_needs_credit: assert property (@(posedge aclk) disable iff (!aresetn)
        wr_dma_valid |-> wr_has_credit)
        else $error("write DMA strobe without a free credit");

    // ----------------------------------------
    // Interrupt
    // ----------------------------------------

    // Reset leaves the interrupt low
    irq_low_after_reset: assert property (@(posedge aclk)
        !aresetn |=> !pf_irq)
        else $error("pf_irq high right after reset");

    // Interrupt rises only together with a fault strobe
    irq_rise_on_fault: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(pf_irq) |-> (rd_pf_valid || wr_pf_valid))
        else $error("pf_irq rose without a fault strobe");

endmodule

bind tlb_region_top tlb_region_sva sva0 (
    .aclk(aclk),
    .aresetn(aresetn),
    .rd_grant(rd_grant),
    .wr_grant(wr_grant),
    .rd_dma_valid(rd_dma_valid),
    .wr_dma_valid(wr_dma_valid),
    .rd_has_credit(rd_has_credit),
    .wr_has_credit(wr_has_credit),
    .rd_pf_valid(rd_pf_valid),
    .wr_pf_valid(wr_pf_valid),
    .pf_irq(pf_irq)
);
